//--- src/drum_defs.svh
// Width, screen and box size macros for the drum pad design, included by RTL and testbench
`ifndef DRUM_DEFS_SVH
`define DRUM_DEFS_SVH

// Polynomial unit
`define DATA_W 4        // Operand and result width

// Pixel coordinates and colour
`define X_W 8           // Screen column
`define Y_W 7           // Screen row, also the coordinate input
`define COLOUR_W 3      // 3-bit RGB

// Display memory size in pixels
`define SCREEN_W 160
`define SCREEN_H 120

// Box drawn per plotBox, scanned 4 columns at a time
`define BOX_W 4
`define BOX_H 32

// Seven-segment digit
`define SEG_W 7         // Segments a to g

`endif

//--- src/poly_pkg.sv
// Types shared by the polynomial sequencer, its datapath and the control interface between them
`include "drum_defs.svh"

package poly_pkg;

    // Operand and result word
    typedef logic [`DATA_W-1:0] nibble_t;

    // Operand register feeding an ALU input
    // Values double as the index into the operand register file
    typedef enum logic [1:0] {
        SelA = 2'd0,
        SelB = 2'd1,
        SelC = 2'd2,
        SelX = 2'd3
    } regSel_e;

    // ALU operation, results truncated to the operand width
    typedef enum logic {
        OpAdd = 1'b0,
        OpMul = 1'b1
    } aluOp_e;

endpackage

//--- src/draw_pkg.sv
// Types of the pixel side, used by the box painter and the top level pixel ports
`include "drum_defs.svh"

package draw_pkg;

    // Screen column, 0 to 159
    typedef logic [`X_W-1:0] xCoord_t;

    // Screen row, 0 to 119
    typedef logic [`Y_W-1:0] yCoord_t;

    // Pixel colour
    typedef logic [`COLOUR_W-1:0] colour_t;

    // One pixel write to the display memory
    typedef struct packed {
        xCoord_t x;
        yCoord_t y;
        colour_t colour;
    } pixel_t;

endpackage

//--- src/poly_ctrl_if.sv
// Control bundle from the polynomial sequencer to the polynomial datapath
`timescale 1ns/1ps

interface polyCtrlIf;

    logic ldA;                    // Operand load strobes
    logic ldB;
    logic ldC;
    logic ldX;
    logic ldR;                    // Result register load
    logic ldAluOut;               // A and B take the ALU output, not dataIn
    poly_pkg::regSel_e selA;      // ALU input selects
    poly_pkg::regSel_e selB;
    poly_pkg::aluOp_e op;

    modport sequencer (
        output ldA, ldB, ldC, ldX, ldR, ldAluOut, selA, selB, op
    );

    modport datapath (
        input ldA, ldB, ldC, ldX, ldR, ldAluOut, selA, selB, op
    );

endinterface

//--- src/polySequencer.sv
// FSM of the polynomial unit, loads four operands on the go handshake and runs the micro-steps
`timescale 1ns/1ps

module polySequencer (
    input  logic         clk,
    input  logic         rst,
    input  logic         go,
    output logic         resultValid,
    polyCtrlIf.sequencer ctrl
);

    typedef enum logic [3:0] {
        LoadA, WaitA,
        LoadB, WaitB,
        LoadC, WaitC,
        LoadX, WaitX,
        MulAA, MulAX, MulBC, AddAB,
        LoadR,
        Valid
    } seqState_e;

    seqState_e state;
    seqState_e nextState;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= LoadA;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            LoadA, Valid: if (go) nextState = WaitA;   // Valid also waits for the next A
            WaitA:        if (!go) nextState = LoadB;
            LoadB:        if (go) nextState = WaitB;
            WaitB:        if (!go) nextState = LoadC;
            LoadC:        if (go) nextState = WaitC;
            WaitC:        if (!go) nextState = LoadX;
            LoadX:        if (go) nextState = WaitX;
            WaitX:        if (!go) nextState = MulAA;
            MulAA:        nextState = MulAX;
            MulAX:        nextState = MulBC;
            MulBC:        nextState = AddAB;
            AddAB:        nextState = LoadR;
            LoadR:        nextState = Valid;
            default:      nextState = LoadA;
        endcase
    end

    // Operand strobes fire on the go-high sample, the capture that counts
    always_comb begin
        ctrl.ldA      = 1'b0;
        ctrl.ldB      = 1'b0;
        ctrl.ldC      = 1'b0;
        ctrl.ldX      = 1'b0;
        ctrl.ldR      = 1'b0;
        ctrl.ldAluOut = 1'b0;
        ctrl.selA     = poly_pkg::SelA;
        ctrl.selB     = poly_pkg::SelA;
        ctrl.op       = poly_pkg::OpAdd;
        resultValid   = 1'b0;
        case (state)
            LoadA: ctrl.ldA = go;
            LoadB: ctrl.ldB = go;
            LoadC: ctrl.ldC = go;
            LoadX: ctrl.ldX = go;
            // Square first, while A still holds the loaded operand
            MulAA: begin
                ctrl.ldA      = 1'b1;
                ctrl.ldAluOut = 1'b1;
                ctrl.op       = poly_pkg::OpMul;
            end
            MulAX: begin                                // A*A*X
                ctrl.ldA      = 1'b1;
                ctrl.ldAluOut = 1'b1;
                ctrl.selB     = poly_pkg::SelX;
                ctrl.op       = poly_pkg::OpMul;
            end
            MulBC: begin
                ctrl.ldB      = 1'b1;
                ctrl.ldAluOut = 1'b1;
                ctrl.selA     = poly_pkg::SelB;
                ctrl.selB     = poly_pkg::SelC;
                ctrl.op       = poly_pkg::OpMul;
            end
            AddAB: begin
                ctrl.ldA      = 1'b1;
                ctrl.ldAluOut = 1'b1;
                ctrl.selB     = poly_pkg::SelB;
            end
            LoadR: ctrl.ldR = 1'b1;
            Valid: begin
                resultValid = 1'b1;
                ctrl.ldA    = go;                       // First operand of the next set
            end
            default: ;
        endcase
    end

endmodule

//--- src/polyDatapath.sv
// Operand registers, shared adder/multiplier and result register of the polynomial unit
`timescale 1ns/1ps

module polyDatapath (
    input  logic              clk,
    input  logic              rst,
    input  poly_pkg::nibble_t dataIn,
    output poly_pkg::nibble_t result,
    polyCtrlIf.datapath       ctrl
);

    // Register file indexed by the ALU select encoding
    poly_pkg::nibble_t opReg [4];

    poly_pkg::nibble_t aluA;
    poly_pkg::nibble_t aluB;
    poly_pkg::nibble_t aluOut;

    // A and B also hold intermediate products
    always_ff @(posedge clk) begin
        if (ctrl.ldA) begin
            opReg[poly_pkg::SelA] <= ctrl.ldAluOut ? aluOut : dataIn;
        end
        if (ctrl.ldB) begin
            opReg[poly_pkg::SelB] <= ctrl.ldAluOut ? aluOut : dataIn;
        end
        if (ctrl.ldC) begin
            opReg[poly_pkg::SelC] <= dataIn;
        end
        if (ctrl.ldX) begin
            opReg[poly_pkg::SelX] <= dataIn;
        end
    end

    // ALU input muxes
    assign aluA = opReg[ctrl.selA];
    assign aluB = opReg[ctrl.selB];

    // Sum and product kept modulo 16
    always_comb begin
        case (ctrl.op)
            poly_pkg::OpMul: aluOut = aluA * aluB;
            default:         aluOut = aluA + aluB;
        endcase
    end

    // Final sum sits in A after the last micro-step
    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
        end else if (ctrl.ldR) begin
            result <= opReg[poly_pkg::SelA];
        end
    end

endmodule

//--- src/boxPainter.sv
// Latches box corner and colour, then streams box or full-screen clear pixels to the display memory
`timescale 1ns/1ps
`include "drum_defs.svh"

module boxPainter (
    input  logic              clk,
    input  logic              rst,
    input  logic [`Y_W-1:0]   coord,
    input  logic              loadX,
    input  logic              plotBox,
    input  logic              black,
    input  draw_pkg::colour_t boxColour,
    output draw_pkg::pixel_t  pixel,
    output logic              plot
);

    localparam int BoxPixels = `BOX_W * `BOX_H;
    localparam int CntW = $clog2(BoxPixels);
    localparam int ColBits = $clog2(`BOX_W);

    typedef enum logic [2:0] {Idle, WaitX, LoadY, WaitY, Draw, Clear} paintState_e;

    paintState_e state;
    paintState_e nextState;

    logic [CntW-1:0]   boxCnt;                 // Index of the box pixel being emitted
    draw_pkg::xCoord_t xReg, clrCol, clrX;
    draw_pkg::yCoord_t yReg, clrRow, clrY;
    draw_pkg::colour_t colourReg;
    draw_pkg::pixel_t  nextPixel;
    logic              boxEmit, clrEmit, clrLast;

    // Black restarts the scan at the origin
    assign clrX    = black ? '0 : clrCol;
    assign clrY    = black ? '0 : clrRow;
    assign clrLast = (clrX == `SCREEN_W - 1) && (clrY == `SCREEN_H - 1);
    assign clrEmit = black || (state == Clear);
    assign boxEmit = !black && ((state == WaitY && !plotBox) || state == Draw);

    always_comb begin
        nextState = state;
        case (state)
            Idle:    if (loadX) nextState = WaitX;
            WaitX:   if (!loadX) nextState = LoadY;
            LoadY:   if (plotBox) nextState = WaitY;
            WaitY:   if (!plotBox) nextState = Draw;
            Draw:    if (boxCnt == CntW'(BoxPixels - 1)) nextState = Idle;
            Clear:   if (clrLast) nextState = Idle;
            default: nextState = Idle;
        endcase
        if (black) begin
            nextState = Clear;                  // Overrides any state
        end
    end

    always_comb begin
        if (clrEmit) begin
            nextPixel.x      = clrX;
            nextPixel.y      = clrY;
            nextPixel.colour = '0;
        end else begin
            nextPixel.x      = xReg + draw_pkg::xCoord_t'(boxCnt[ColBits-1:0]);
            nextPixel.y      = yReg + draw_pkg::yCoord_t'(boxCnt >> ColBits);
            nextPixel.colour = colourReg;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= Idle;
            plot   <= 1'b0;
            boxCnt <= '0;
            clrCol <= '0;
            clrRow <= '0;
        end else begin
            state  <= nextState;
            plot   <= boxEmit || clrEmit;
            boxCnt <= boxEmit ? boxCnt + 1'b1 : '0;   // Wraps to 0 after the last pixel
            if (clrEmit && !clrLast) begin
                if (clrX == `SCREEN_W - 1) begin    // End of row
                    clrCol <= '0;
                    clrRow <= clrY + 1'b1;
                end else begin
                    clrCol <= clrX + 1'b1;
                    clrRow <= clrY;
                end
            end else begin
                clrCol <= '0;
                clrRow <= '0;
            end
        end
    end

    // Coordinates captured every cycle of their load state
    always_ff @(posedge clk) begin
        if (state == Idle) begin
            xReg <= draw_pkg::xCoord_t'(coord);
        end
        if (state == LoadY) begin
            yReg      <= coord;
            colourReg <= boxColour;
        end
        pixel <= nextPixel;
    end

endmodule

//--- src/segDecoder.sv
// Hex digit to active-low seven-segment pattern, bit 0 drives segment a
`timescale 1ns/1ps
`include "drum_defs.svh"

module segDecoder (
    input  poly_pkg::nibble_t   digit,
    output logic [`SEG_W-1:0]   seg
);

    // Patterns are gfedcba, a low bit lights the segment
    always_comb begin
        seg = '1;                               // Blank
        case (digit)
            4'h0: seg = 7'b1000000;
            4'h1: seg = 7'b1111001;
            4'h2: seg = 7'b0100100;
            4'h3: seg = 7'b0110000;
            4'h4: seg = 7'b0011001;
            4'h5: seg = 7'b0010010;
            4'h6: seg = 7'b0000010;
            4'h7: seg = 7'b1111000;
            4'h8: seg = 7'b0000000;
            4'h9: seg = 7'b0010000;
            4'hA: seg = 7'b0001000;
            4'hB: seg = 7'b0000011;             // Lower case b
            4'hC: seg = 7'b1000110;
            4'hD: seg = 7'b0100001;             // Lower case d
            4'hE: seg = 7'b0000110;
            4'hF: seg = 7'b0001110;
            default: ;
        endcase
    end

endmodule

//--- src/drumPadDisplay.sv
// Top level joining the polynomial unit, the box painter and the result digit on plain ports
`timescale 1ns/1ps
`include "drum_defs.svh"

module drumPadDisplay (
    input  logic               clk,
    input  logic               rst,
    input  poly_pkg::nibble_t  dataIn,
    input  logic               go,
    input  logic [`Y_W-1:0]    coord,
    input  logic               loadX,
    input  logic               plotBox,
    input  logic               black,
    output poly_pkg::nibble_t  result,
    output logic               resultValid,
    output logic [`SEG_W-1:0]  hexResult,
    output draw_pkg::xCoord_t  pixX,
    output draw_pkg::yCoord_t  pixY,
    output draw_pkg::colour_t  pixColour,
    output logic               plot
);

    polyCtrlIf ctrl ();

    draw_pkg::pixel_t pixel;

    polySequencer uSequencer (
        .clk         (clk),
        .rst         (rst),
        .go          (go),
        .resultValid (resultValid),
        .ctrl        (ctrl)
    );

    polyDatapath uDatapath (
        .clk    (clk),
        .rst    (rst),
        .dataIn (dataIn),
        .result (result),
        .ctrl   (ctrl)
    );

    // Box colour follows the low bits of the current result
    boxPainter uPainter (
        .clk       (clk),
        .rst       (rst),
        .coord     (coord),
        .loadX     (loadX),
        .plotBox   (plotBox),
        .black     (black),
        .boxColour (result[`COLOUR_W-1:0]),
        .pixel     (pixel),
        .plot      (plot)
    );

    segDecoder uSeg (
        .digit (result),
        .seg   (hexResult)
    );

    assign pixX      = pixel.x;
    assign pixY      = pixel.y;
    assign pixColour = pixel.colour;

endmodule

//--- tests/drumPad_props.sv
// Checker bound to the drum pad top level that tracks operands and box corners from the handshakes
`timescale 1ns/1ps
`include "drum_defs.svh"

module drumPad_props (
    input logic                clk,
    input logic                rst,
    input poly_pkg::nibble_t   dataIn,
    input logic                go,
    input logic [`Y_W-1:0]     coord,
    input logic                loadX,
    input logic                plotBox,
    input logic                black,
    input poly_pkg::nibble_t   result,
    input logic                resultValid,
    input logic [`SEG_W-1:0]   hexResult,
    input draw_pkg::xCoord_t   pixX,
    input draw_pkg::yCoord_t   pixY,
    input draw_pkg::colour_t   pixColour,
    input logic                plot
);

    // Active-low gfedcba patterns for 0 to F
    localparam logic [`SEG_W-1:0] SegTable [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
    };

    int assertFails = 0;                // Failed assertion count

    poly_pkg::nibble_t opnd [4];        // A, B, C, X in load order
    logic [1:0]        opIdx;
    logic              opWait;
    logic [1:0]        drawPhase;       // X, X release, Y, Y release
    draw_pkg::xCoord_t xCap;
    draw_pkg::yCoord_t yCap;
    draw_pkg::colour_t colCap;
    logic              boxOn;
    logic [6:0]        boxIdx;
    logic              clrOn;
    draw_pkg::xCoord_t clrCol;
    draw_pkg::yCoord_t clrRow;
    poly_pkg::nibble_t expResult;
    draw_pkg::xCoord_t expBoxX;
    draw_pkg::yCoord_t expBoxY;

    assign expResult = opnd[0] * opnd[3] * opnd[0] + opnd[1] * opnd[2];   // Wraps mod 16
    assign expBoxX   = xCap + draw_pkg::xCoord_t'(boxIdx % `BOX_W);
    assign expBoxY   = yCap + draw_pkg::yCoord_t'(boxIdx / `BOX_W);

    // First go-high sample is the operand
    always_ff @(posedge clk) begin
        if (rst) begin
            opIdx  <= '0;
            opWait <= 1'b0;
        end else if (!opWait && go) begin
            opnd[opIdx] <= dataIn;
            opWait      <= 1'b1;
        end else if (opWait && !go) begin
            opWait <= 1'b0;
            opIdx  <= opIdx + 1'b1;
        end
    end

    // Expected pixel stream
    always_ff @(posedge clk) begin
        if (rst) begin
            drawPhase <= '0;
            boxOn     <= 1'b0;
            clrOn     <= 1'b0;
        end else if (black) begin
            drawPhase <= '0;
            boxOn     <= 1'b0;
            clrOn     <= 1'b1;
            clrCol    <= '0;
            clrRow    <= '0;
        end else begin
            case (drawPhase)
                2'd0: if (loadX) begin
                    xCap      <= draw_pkg::xCoord_t'(coord);
                    drawPhase <= 2'd1;
                end
                2'd1: if (!loadX) drawPhase <= 2'd2;
                2'd2: if (plotBox) begin
                    yCap      <= coord;
                    colCap    <= result[`COLOUR_W-1:0];
                    drawPhase <= 2'd3;
                end
                default: if (!plotBox) begin
                    drawPhase <= 2'd0;
                    boxOn     <= 1'b1;
                    boxIdx    <= '0;
                end
            endcase
            if (boxOn) begin
                boxIdx <= boxIdx + 1'b1;
                if (boxIdx == `BOX_W * `BOX_H - 1) boxOn <= 1'b0;
            end
            if (clrOn) begin
                if (clrCol == `SCREEN_W - 1) begin   // Next row
                    clrCol <= '0;
                    clrRow <= clrRow + 1'b1;
                    if (clrRow == `SCREEN_H - 1) clrOn <= 1'b0;
                end else begin
                    clrCol <= clrCol + 1'b1;
                end
            end
        end
    end

    assert property (@(posedge clk) rst |=> !plot && !resultValid && result == '0)
        else begin
            assertFails++;
            $error("ERR %0t: outputs not idle after reset", $time);
        end

    // Last go-low sample of a set to the resultValid rise
    assert property (@(posedge clk) disable iff (rst)
        opWait && !go && opIdx == 2'd3 |-> ##6 $rose(resultValid))
        else begin
            assertFails++;
            $error("ERR %0t: resultValid not raised six cycles after operand X", $time);
        end

    assert property (@(posedge clk) disable iff (rst) resultValid && !go |=> resultValid)
        else begin
            assertFails++;
            $error("ERR %0t: resultValid dropped before the next go", $time);
        end

    assert property (@(posedge clk) disable iff (rst) resultValid |-> result == expResult)
        else begin
            assertFails++;
            $error("ERR %0t: result %h, expected %h", $time, $sampled(result),
                   $sampled(expResult));
        end

    assert property (@(posedge clk) disable iff (rst)
        resultValid |-> hexResult == SegTable[result])
        else begin
            assertFails++;
            $error("ERR %0t: seven-segment pattern does not match result", $time);
        end

    assert property (@(posedge clk) disable iff (rst)
        boxOn |-> plot && pixX == expBoxX && pixY == expBoxY && pixColour == colCap)
        else begin
            assertFails++;
            $error("ERR %0t: box pixel %0d wrong or missing", $time, $sampled(boxIdx));
        end

    assert property (@(posedge clk) disable iff (rst)
        clrOn |-> plot && pixX == clrCol && pixY == clrRow && pixColour == '0)
        else begin
            assertFails++;
            $error("ERR %0t: clear pixel wrong or missing", $time);
        end

    assert property (@(posedge clk) disable iff (rst) !boxOn && !clrOn |-> !plot)
        else begin
            assertFails++;
            $error("ERR %0t: plot high outside a box or clear", $time);
        end

endmodule

bind drumPadDisplay drumPad_props i_props (
    .clk(clk), .rst(rst), .dataIn(dataIn), .go(go), .coord(coord),
    .loadX(loadX), .plotBox(plotBox), .black(black), .result(result),
    .resultValid(resultValid), .hexResult(hexResult), .pixX(pixX),
    .pixY(pixY), .pixColour(pixColour), .plot(plot)
);

//--- tests/tb_drumPad.sv
// Testbench for the drum pad top level, runs operand sets, boxes and a clear, counts plot cycles
`timescale 1ns/1ps
`include "drum_defs.svh"

module tb_drumPad;

    logic               clk = 1'b0;
    logic               rst;
    poly_pkg::nibble_t  dataIn;
    logic               go;
    logic [`Y_W-1:0]    coord;
    logic               loadX;
    logic               plotBox;
    logic               black;
    poly_pkg::nibble_t  result;
    logic               resultValid;
    logic [`SEG_W-1:0]  hexResult;
    draw_pkg::xCoord_t  pixX;
    draw_pkg::yCoord_t  pixY;
    draw_pkg::colour_t  pixColour;
    logic               plot;

    integer seed;
    int     countErrs;
    int     timeouts;

    drumPadDisplay i_dut (.*);

    always #2 clk = ~clk;

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic finishRun();
        repeat (2) tick();                       // Pending assertion actions
        $display("errors: %0d plot count, %0d timeout, %0d assertion",
                 countErrs, timeouts, i_dut.i_props.assertFails);
        if (countErrs == 0 && timeouts == 0 && i_dut.i_props.assertFails == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    task automatic timedOut(input string what);
        $display("Timed out waiting for %s at %0t ns", what, $time);
        timeouts++;
        finishRun();
    endtask

    // Data steady a cycle before go and until go falls
    task automatic sendOperand(input poly_pkg::nibble_t value);
        dataIn = value;
        tick();
        go = 1'b1;
        tick();
        go = 1'b0;
        tick();
    endtask

    task automatic sendCoord(input logic [`Y_W-1:0] value, input logic isY);
        coord = value;
        tick();
        if (isY) plotBox = 1'b1;
        else loadX = 1'b1;
        tick();
        loadX   = 1'b0;
        plotBox = 1'b0;
        tick();
    endtask

    task automatic runPolySet();
        int waitCnt;
        repeat (4) sendOperand(poly_pkg::nibble_t'($random(seed)));
        waitCnt = 0;
        while (!resultValid && waitCnt < 20) begin
            tick();
            waitCnt++;
        end
        if (!resultValid) timedOut("resultValid");
        tick();
    endtask

    task automatic waitForPlot(input string what);
        int waitCnt;
        waitCnt = 0;
        while (!plot && waitCnt < 10) begin
            tick();
            waitCnt++;
        end
        if (!plot) timedOut(what);
    endtask

    // Consecutive plot-high cycles from the first one seen
    task automatic countPlots(input int expected, input string what);
        int n;
        waitForPlot(what);
        n = 0;
        while (plot && n <= expected) begin
            n++;
            tick();
        end
        if (n != expected) begin
            countErrs++;
            $display("ERR %0t: %s gave %0d plot cycles, expected %0d", $time, what, n, expected);
        end
    endtask

    task automatic startBox();
        sendCoord(`Y_W'($random(seed)), 1'b0);    // Any 7-bit column fits
        sendCoord(`Y_W'($unsigned($random(seed)) % (`SCREEN_H - `BOX_H + 1)), 1'b1);
    endtask

    initial begin
        seed      = 32'hb400_46c3;
        countErrs = 0;
        timeouts  = 0;
        rst       = 1'b1;
        dataIn    = '0;
        go        = 1'b0;
        coord     = '0;
        loadX     = 1'b0;
        plotBox   = 1'b0;
        black     = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        repeat (3) tick();
        for (int i = 0; i < 10; i++) begin
            runPolySet();
            startBox();
            countPlots(`BOX_W * `BOX_H, "box");
        end
        startBox();
        waitForPlot("box before black");
        repeat (40) tick();                       // Mid-box
        black = 1'b1;
        tick();
        black = 1'b0;
        countPlots(`SCREEN_W * `SCREEN_H, "clear");
        repeat (20) tick();
        runPolySet();
        startBox();
        countPlots(`BOX_W * `BOX_H, "box after clear");
        finishRun();
    end

endmodule

//--- sim.f
+incdir+src
src/poly_pkg.sv
src/draw_pkg.sv
src/poly_ctrl_if.sv
src/polySequencer.sv
src/polyDatapath.sv
src/boxPainter.sv
src/segDecoder.sv
src/drumPadDisplay.sv
tests/drumPad_props.sv
tests/tb_drumPad.sv
